// File: src.f
+incdir+include
src/isaPkg.sv
src/pipePkg.sv
src/stageRegister.sv
src/registerFile.sv
src/hazardUnit.sv
src/executeUnit.sv
src/pipelineCpu.sv
tb/pipelineCpuTb.sv

// File: Makefile
# Verilator build and run of the pipelined core testbench

TOP = pipelineCpuTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f src.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf obj_dir

// File: tb/pipelineCpuTb.sv
////////////////////
// Testbench for the pipelined core with a random forward-only program and an ISA model
// Every data memory store is compared in order against the model's store sequence
////////////////////
`include "cpu_defines.svh"

module pipelineCpuTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam int clockPeriod   = 100;
    localparam int resetCycles   = 8;
    localparam int programLength = 200;
    localparam int haltAddress   = programLength - 1;
    localparam int memDepth      = 1 << `CPU_DMEM_INDEX_WIDTH;

    logic                       clock;
    logic                       reset;
    logic [`CPU_DATA_WIDTH-1:0] imemAddress;
    logic [`CPU_DATA_WIDTH-1:0] imemData;
    MemRequest                  dmemRequest;
    logic [`CPU_DATA_WIDTH-1:0] dmemReadData;

    logic [`CPU_DATA_WIDTH-1:0] imem [memDepth];
    logic [`CPU_DATA_WIDTH-1:0] dmem [memDepth];
    logic [`CPU_DATA_WIDTH-1:0] modelMem [memDepth];
    logic [`CPU_DATA_WIDTH-1:0] expectedAddress [$];
    logic [`CPU_DATA_WIDTH-1:0] expectedData [$];
    logic [31:0]                lfsrState;
    int                         modelStoreCount;
    int                         storeCount;
    int                         haltCycles;

    pipelineCpu pipelineCpu_i (
        .clock(clock), .reset(reset), .imemAddress(imemAddress), .imemData(imemData),
        .dmemRequest(dmemRequest), .dmemReadData(dmemReadData)
    );

    always #(clockPeriod / 2) clock = ~clock;

    ////////////////////
    // Memories
    // Both answer in the same cycle and stores land on the rising edge
    assign imemData     = imem[imemAddress[`CPU_DMEM_INDEX_WIDTH-1:0]];
    assign dmemReadData = dmem[dmemRequest.address[`CPU_DMEM_INDEX_WIDTH-1:0]];

    always @(posedge clock) begin
        if (dmemRequest.writeEnable) begin
            dmem[dmemRequest.address[`CPU_DMEM_INDEX_WIDTH-1:0]] <= dmemRequest.writeData;
        end
    end

    // Galois LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] randomBits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
        end
        return value;
    endfunction

    // Odd multiplier spreads every address bit into the word
    function automatic logic [31:0] fillWord(int index);
        return 32'h9E37_79B9 * (index + 1);
    endfunction

    task automatic compareValue(input string what, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s mismatch, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    ////////////////////
    // Program generator
    // Only registers r0..r7 are used so dependencies come often
    task automatic buildProgram();
        logic [31:0] kind;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  lastRd;
        logic [16:0] imm;
        int          target;
        lastRd = 5'd1;
        for (int i = 0; i < 7; i++) begin
            imem[i] = {opAddi, 5'(i + 1), 5'd0, 17'(randomBits(17))};
        end
        for (int i = 7; i < haltAddress; i++) begin
            kind   = randomBits(4);
            rd     = 5'(randomBits(3));
            rs     = 5'(randomBits(3));
            target = i + 1 + int'(randomBits(2));
            if (target > haltAddress) begin
                target = haltAddress;
            end
            if (kind <= 4) begin
                imem[i] = {opAlu, rd, rs, 5'(randomBits(3)), 5'(randomBits(5)),
                           AluOp'(5'(randomBits(3) % 6)), 2'b00};
                lastRd  = rd;
            end else if (kind <= 6) begin
                imem[i] = {opAddi, rd, rs, 17'(randomBits(17))};
                lastRd  = rd;
            end else if (kind <= 8 || kind == 15) begin
                // Mostly a store of the latest result
                imm     = 17'(randomBits(4));
                imem[i] = {opSw, (kind == 15) ? rd : lastRd, rs, imm};
            end else if (kind <= 10) begin
                imem[i] = {opLw, rd, rs, 17'(randomBits(4))};
                lastRd  = rd;
            end else if (kind <= 13) begin
                imm     = 17'(target - (i + 1));
                imem[i] = {(kind == 13) ? opBlt : opBne, rd, rs, imm};
            end else begin
                imem[i] = {opJ, 27'(target)};
            end
        end
        // Halt is a jump to itself
        imem[haltAddress] = {opJ, 27'(haltAddress)};
    endtask

    ////////////////////
    // ISA model that runs one instruction at a time
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] word;
        logic [31:0] pc;
        logic [31:0] pcNext;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] address;
        logic [31:0] result;
        logic        writeReg;
        Instruction  ins;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc    = '0;
        steps = 0;
        while (pc != haltAddress && steps < 4 * programLength) begin
            word     = imem[pc[`CPU_DMEM_INDEX_WIDTH-1:0]];
            ins      = Instruction'(word);
            imm      = {{15{word[16]}}, word[16:0]};
            a        = regs[ins.rs];
            b        = (ins.opcode inside {opBne, opBlt, opSw}) ? regs[ins.rd] : regs[ins.rt];
            address  = a + imm;
            pcNext   = pc + 1;
            writeReg = 1'b0;
            result   = '0;
            case (ins.opcode)
                opAlu: begin
                    writeReg = 1'b1;
                    case (ins.aluOp)
                        aluSub:  result = a - b;
                        aluAnd:  result = a & b;
                        aluOr:   result = a | b;
                        aluSll:  result = a << ins.shamt;
                        aluSra:  result = $signed(a) >>> ins.shamt;
                        default: result = a + b;
                    endcase
                end
                opAddi: begin
                    writeReg = 1'b1;
                    result   = address;
                end
                opLw: begin
                    writeReg = 1'b1;
                    result   = modelMem[address[`CPU_DMEM_INDEX_WIDTH-1:0]];
                end
                opSw: begin
                    modelMem[address[`CPU_DMEM_INDEX_WIDTH-1:0]] = b;
                    expectedAddress.push_back(address);
                    expectedData.push_back(b);
                end
                opBne:   pcNext = (b != a) ? pc + 1 + imm : pcNext;
                opBlt:   pcNext = ($signed(b) < $signed(a)) ? pc + 1 + imm : pcNext;
                opJ:     pcNext = {{5{word[26]}}, word[26:0]};
                default: pcNext = pc + 1;
            endcase
            // r0 stays zero
            if (writeReg && ins.rd != 0) begin
                regs[ins.rd] = result;
            end
            pc = pcNext;
            steps++;
        end
        modelStoreCount = expectedAddress.size();
    endtask

    ////////////////////
    // Store checker samples the request mid-cycle
    always @(negedge clock) begin
        if (!reset && dmemRequest.writeEnable) begin
            if (expectedAddress.size() == 0) begin
                $display("Store to %h at time %0t has no matching store in the model",
                         dmemRequest.address, $time);
                $display("Simulation FAILED");
                $fatal(1, "unexpected store");
            end else begin
                compareValue("store address", dmemRequest.address, expectedAddress.pop_front());
                compareValue("store data", dmemRequest.writeData, expectedData.pop_front());
                storeCount++;
            end
        end
    end

    // Worst case is a few cycles per instruction
    initial begin
        #((resetCycles + programLength * 4 + 100) * clockPeriod);
        $display("Timeout: the core never settled in the halt loop");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clock      = 1'b0;
        reset      = 1'b1;
        lfsrState  = 32'h3516;
        storeCount = 0;
        for (int i = 0; i < memDepth; i++) begin
            imem[i]     = '0;
            dmem[i]     = fillWord(i);
            modelMem[i] = fillWord(i);
        end
        buildProgram();
        runModel();

        // No fetch movement and no store while in reset
        @(posedge clock);
        repeat (resetCycles - 1) begin
            @(negedge clock);
            compareValue("imemAddress in reset", imemAddress, '0);
            compareValue("writeEnable in reset", 32'(dmemRequest.writeEnable), '0);
            @(posedge clock);
        end
        reset <= 1'b0;
        @(negedge clock);
        compareValue("imemAddress after reset", imemAddress, '0);

        // Halt loop spans the jump and the two squashed fetches behind it
        haltCycles = 0;
        while (haltCycles < 10) begin
            @(negedge clock);
            if (imemAddress >= haltAddress && imemAddress <= haltAddress + 2) begin
                haltCycles++;
            end else begin
                haltCycles = 0;
            end
        end
        @(posedge clock);

        if (storeCount != modelStoreCount) begin
            $display("Store count is %0d, but the model made %0d stores",
                     storeCount, modelStoreCount);
            $display("Simulation FAILED");
            $fatal(1, "store count mismatch");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: src/pipelineCpu.sv
////////////////////
// Five-stage core top level; the testbench attaches instruction and data memory
////////////////////
`include "cpu_defines.svh"

module pipelineCpu (
    input  logic                       clock,
    input  logic                       reset,
    output logic [`CPU_DATA_WIDTH-1:0] imemAddress,
    input  logic [`CPU_DATA_WIDTH-1:0] imemData,
    output pipePkg::MemRequest         dmemRequest,
    input  logic [`CPU_DATA_WIDTH-1:0] dmemReadData
);
    import isaPkg::*;
    import pipePkg::*;

    logic [`CPU_DATA_WIDTH-1:0]     pc;
    logic [`CPU_DATA_WIDTH-1:0]     pcNext;
    FetchDecode                     fetchOut;
    FetchDecode                     decodeStage;
    DecodeExecute                   decodeOut;
    DecodeExecute                   executeStage;
    ExecuteMemory                   executeOut;
    ExecuteMemory                   memoryStage;
    MemoryWriteback                 memoryOut;
    MemoryWriteback                 writebackStage;
    ForwardSelect                   forwardA;
    ForwardSelect                   forwardB;
    logic                           forwardStore;
    logic                           stall;
    logic                           flush;
    logic                           taken;
    logic [`CPU_DATA_WIDTH-1:0]     executeResult;
    logic [`CPU_DATA_WIDTH-1:0]     storeValue;
    logic [`CPU_DATA_WIDTH-1:0]     target;
    logic [`CPU_REG_ADDR_WIDTH-1:0] readAddressB;
    logic [`CPU_DATA_WIDTH-1:0]     readDataA;
    logic [`CPU_DATA_WIDTH-1:0]     readDataB;
    logic                           writebackEnable;
    logic [`CPU_DATA_WIDTH-1:0]     writebackData;

    ////////////////////
    // Fetch
    assign pcNext      = pc + 1'b1;
    assign imemAddress = pc;

    // Redirect beats stall, both never come from the same execute instruction
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else if (flush) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pcNext;
        end
    end

    assign fetchOut.instruction = Instruction'(imemData);
    assign fetchOut.pcNext      = pcNext;

    stageRegister #(.Payload(FetchDecode)) fetchDecode_i (
        .clock(clock), .reset(reset), .hold(stall), .bubble(flush),
        .d(fetchOut), .q(decodeStage)
    );

    ////////////////////
    // Decode
    // Port B reads rd for bne, blt and sw
    assign readAddressB = readsRdAsOperandB(decodeStage.instruction) ?
                          decodeStage.instruction.rd : decodeStage.instruction.rt;

    registerFile registerFile_i (
        .clock(clock), .reset(reset),
        .readAddressA(decodeStage.instruction.rs), .readAddressB(readAddressB),
        .readDataA(readDataA), .readDataB(readDataB),
        .writeEnable(writebackEnable), .writeAddress(writebackStage.instruction.rd),
        .writeData(writebackData)
    );

    assign decodeOut.instruction = decodeStage.instruction;
    assign decodeOut.pcNext      = decodeStage.pcNext;
    assign decodeOut.readA       = readDataA;
    assign decodeOut.readB       = readDataB;

    // Load-use and redirect both insert a bubble here
    stageRegister #(.Payload(DecodeExecute)) decodeExecute_i (
        .clock(clock), .reset(reset), .hold(1'b0), .bubble(stall || flush),
        .d(decodeOut), .q(executeStage)
    );

    hazardUnit hazardUnit_i (
        .decodeInstruction(decodeStage.instruction),
        .executeInstruction(executeStage.instruction),
        .memoryInstruction(memoryStage.instruction),
        .writebackInstruction(writebackStage.instruction),
        .taken(taken), .forwardA(forwardA), .forwardB(forwardB),
        .forwardStore(forwardStore), .stall(stall), .flush(flush)
    );

    ////////////////////
    // Execute
    executeUnit executeUnit_i (
        .stage(executeStage), .forwardA(forwardA), .forwardB(forwardB),
        .memoryResult(memoryStage.aluResult), .writebackResult(writebackData),
        .result(executeResult), .storeValue(storeValue), .taken(taken), .target(target)
    );

    assign executeOut.instruction = executeStage.instruction;
    assign executeOut.aluResult   = executeResult;
    assign executeOut.storeValue  = storeValue;

    stageRegister #(.Payload(ExecuteMemory)) executeMemory_i (
        .clock(clock), .reset(reset), .hold(1'b0), .bubble(1'b0),
        .d(executeOut), .q(memoryStage)
    );

    ////////////////////
    // Memory
    assign dmemRequest.address     = memoryStage.aluResult;
    assign dmemRequest.writeData   = forwardStore ? writebackData : memoryStage.storeValue;
    assign dmemRequest.writeEnable = (memoryStage.instruction.opcode == opSw);

    assign memoryOut.instruction = memoryStage.instruction;
    assign memoryOut.aluResult   = memoryStage.aluResult;
    assign memoryOut.loadData    = dmemReadData;

    stageRegister #(.Payload(MemoryWriteback)) memoryWriteback_i (
        .clock(clock), .reset(reset), .hold(1'b0), .bubble(1'b0),
        .d(memoryOut), .q(writebackStage)
    );

    ////////////////////
    // Writeback
    // Register file drops writes to r0, so bubbles are harmless
    assign writebackEnable = writesRegister(writebackStage.instruction);
    assign writebackData   = (writebackStage.instruction.opcode == opLw) ?
                             writebackStage.loadData : writebackStage.aluResult;

endmodule

// File: src/executeUnit.sv
////////////////////
// Execute stage: bypass muxes, ALU, branch and jump resolution
////////////////////
`include "cpu_defines.svh"

module executeUnit (
    input  pipePkg::DecodeExecute      stage,
    input  pipePkg::ForwardSelect      forwardA,
    input  pipePkg::ForwardSelect      forwardB,
    input  logic [`CPU_DATA_WIDTH-1:0] memoryResult,
    input  logic [`CPU_DATA_WIDTH-1:0] writebackResult,
    output logic [`CPU_DATA_WIDTH-1:0] result,
    output logic [`CPU_DATA_WIDTH-1:0] storeValue,
    output logic                       taken,
    output logic [`CPU_DATA_WIDTH-1:0] target
);
    import isaPkg::*;
    import pipePkg::*;

    logic [`CPU_DATA_WIDTH-1:0] operandA;
    logic [`CPU_DATA_WIDTH-1:0] operandB;
    logic [`CPU_DATA_WIDTH-1:0] aluInput;
    logic [`CPU_DATA_WIDTH-1:0] immediate;
    logic                       useImmediate;

    function automatic logic [`CPU_DATA_WIDTH-1:0] forwarded(
        ForwardSelect               select,
        logic [`CPU_DATA_WIDTH-1:0] registerValue,
        logic [`CPU_DATA_WIDTH-1:0] memoryValue,
        logic [`CPU_DATA_WIDTH-1:0] writebackValue
    );
        case (select)
            fromMemory:    return memoryValue;
            fromWriteback: return writebackValue;
            default:       return registerValue;
        endcase
    endfunction

    ////////////////////
    // Operands
    // A is rs, B is rt or rd
    assign operandA = forwarded(forwardA, stage.readA, memoryResult, writebackResult);
    assign operandB = forwarded(forwardB, stage.readB, memoryResult, writebackResult);

    assign immediate    = signExtendImmediate(stage.instruction);
    assign useImmediate = stage.instruction.opcode inside {opAddi, opLw, opSw};
    assign aluInput     = useImmediate ? immediate : operandB;

    // Store data is the bypassed rd value
    assign storeValue = operandB;

    ////////////////////
    // ALU
    // Non-R-type opcodes overlap aluOp with immediate bits, so they always add
    always_comb begin
        result = operandA + aluInput;
        if (stage.instruction.opcode == opAlu) begin
            case (stage.instruction.aluOp)
                aluSub:  result = operandA - aluInput;
                aluAnd:  result = operandA & aluInput;
                aluOr:   result = operandA | aluInput;
                aluSll:  result = operandA << stage.instruction.shamt;
                aluSra:  result = $signed(operandA) >>> stage.instruction.shamt;
                default: result = operandA + aluInput;
            endcase
        end
    end

    ////////////////////
    // Control transfer
    // blt takes the branch when rd < rs, signed
    always_comb begin
        case (stage.instruction.opcode)
            opBne:   taken = (operandB != operandA);
            opBlt:   taken = ($signed(operandB) < $signed(operandA));
            opJ:     taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // pcNext already holds PC+1
    assign target = (stage.instruction.opcode == opJ) ? signExtendTarget(stage.instruction) :
                    stage.pcNext + immediate;

endmodule

// File: src/hazardUnit.sv
////////////////////
// Register dependency checks: operand bypass, store bypass, load-use stall, flush
////////////////////
`include "cpu_defines.svh"

module hazardUnit (
    input  isaPkg::Instruction    decodeInstruction,
    input  isaPkg::Instruction    executeInstruction,
    input  isaPkg::Instruction    memoryInstruction,
    input  isaPkg::Instruction    writebackInstruction,
    input  logic                  taken,
    output pipePkg::ForwardSelect forwardA,
    output pipePkg::ForwardSelect forwardB,
    output logic                  forwardStore,
    output logic                  stall,
    output logic                  flush
);
    import isaPkg::*;
    import pipePkg::*;

    logic [`CPU_REG_ADDR_WIDTH-1:0] executeSourceB;
    logic [`CPU_REG_ADDR_WIDTH-1:0] decodeSourceB;
    logic                           loadInExecute;
    logic                           decodeReadsA;
    logic                           decodeReadsB;

    // Producer of a usable result, r0 excluded
    function automatic logic produces(Instruction instruction);
        return writesRegister(instruction) && (instruction.rd != '0);
    endfunction

    // Youngest producer wins, memory stage before writeback
    function automatic ForwardSelect sourceFor(logic [`CPU_REG_ADDR_WIDTH-1:0] source,
                                               Instruction memoryProducer,
                                               Instruction writebackProducer);
        if (produces(memoryProducer) && memoryProducer.rd == source) begin
            return fromMemory;
        end
        if (produces(writebackProducer) && writebackProducer.rd == source) begin
            return fromWriteback;
        end
        return fromRegister;
    endfunction

    ////////////////////
    // Execute operand bypass
    assign executeSourceB = readsRdAsOperandB(executeInstruction) ?
                            executeInstruction.rd : executeInstruction.rt;
    assign forwardA = sourceFor(executeInstruction.rs, memoryInstruction, writebackInstruction);
    assign forwardB = sourceFor(executeSourceB, memoryInstruction, writebackInstruction);

    // Store right behind its producer, e.g. lw r1 then sw r1
    assign forwardStore = (memoryInstruction.opcode == opSw) && produces(writebackInstruction)
                          && (writebackInstruction.rd == memoryInstruction.rd);

    ////////////////////
    // Load-use
    // sw data is left out, the store bypass above covers it
    assign loadInExecute = (executeInstruction.opcode == opLw) && (executeInstruction.rd != '0);
    assign decodeReadsA  = (decodeInstruction.opcode != opJ);
    assign decodeReadsB  = decodeInstruction.opcode inside {opAlu, opBne, opBlt};
    assign decodeSourceB = readsRdAsOperandB(decodeInstruction) ?
                           decodeInstruction.rd : decodeInstruction.rt;

    assign stall = loadInExecute &&
                   ((decodeReadsA && decodeInstruction.rs == executeInstruction.rd) ||
                    (decodeReadsB && decodeSourceB == executeInstruction.rd));

    // Taken branch or jump squashes fetch and decode
    assign flush = taken;

endmodule

// File: src/registerFile.sv
////////////////////
// Register file, two combinational reads and one clocked write
////////////////////
`include "cpu_defines.svh"

module registerFile (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [`CPU_REG_ADDR_WIDTH-1:0] readAddressA,
    input  logic [`CPU_REG_ADDR_WIDTH-1:0] readAddressB,
    output logic [`CPU_DATA_WIDTH-1:0]     readDataA,
    output logic [`CPU_DATA_WIDTH-1:0]     readDataB,
    input  logic                           writeEnable,
    input  logic [`CPU_REG_ADDR_WIDTH-1:0] writeAddress,
    input  logic [`CPU_DATA_WIDTH-1:0]     writeData
);

    logic [`CPU_DATA_WIDTH-1:0] registers [`CPU_REG_COUNT];
    logic                       writeValid;

    // r0 is never written
    assign writeValid = writeEnable && (writeAddress != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else if (writeValid) begin
            registers[writeAddress] <= writeData;
        end
    end

    // Same-cycle write passes straight through to the reader
    assign readDataA = (readAddressA == '0) ? '0 :
                       (writeValid && writeAddress == readAddressA) ? writeData :
                       registers[readAddressA];
    assign readDataB = (readAddressB == '0) ? '0 :
                       (writeValid && writeAddress == readAddressB) ? writeData :
                       registers[readAddressB];

endmodule

// File: src/stageRegister.sv
////////////////////
// Generic pipeline register, one instance per stage boundary
////////////////////
module stageRegister #(
    parameter type Payload = logic
) (
    input  logic   clock,
    input  logic   reset,
    input  logic   hold,
    input  logic   bubble,
    input  Payload d,
    output Payload q
);

    // Bubble wins over hold
    // An all-zero payload is add r0, r0, r0 and changes nothing
    always_ff @(posedge clock) begin
        if (reset || bubble) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: src/pipePkg.sv
////////////////////
// Payloads carried between pipeline stages, plus the data memory request
////////////////////
`include "cpu_defines.svh"

package pipePkg;
    import isaPkg::*;

    // Fetch to decode
    typedef struct packed {
        Instruction                 instruction;
        logic [`CPU_DATA_WIDTH-1:0] pcNext;
    } FetchDecode;

    // Decode to execute
    // readB is rt, or rd for branches and stores
    typedef struct packed {
        Instruction                 instruction;
        logic [`CPU_DATA_WIDTH-1:0] pcNext;
        logic [`CPU_DATA_WIDTH-1:0] readA;
        logic [`CPU_DATA_WIDTH-1:0] readB;
    } DecodeExecute;

    // Execute to memory
    typedef struct packed {
        Instruction                 instruction;
        logic [`CPU_DATA_WIDTH-1:0] aluResult;
        logic [`CPU_DATA_WIDTH-1:0] storeValue;
    } ExecuteMemory;

    // Memory to writeback
    typedef struct packed {
        Instruction                 instruction;
        logic [`CPU_DATA_WIDTH-1:0] aluResult;
        logic [`CPU_DATA_WIDTH-1:0] loadData;
    } MemoryWriteback;

    // Data memory port, write on the clock edge
    typedef struct packed {
        logic [`CPU_DATA_WIDTH-1:0] address;
        logic [`CPU_DATA_WIDTH-1:0] writeData;
        logic                       writeEnable;
    } MemRequest;

    // Source of an execute operand
    typedef enum logic [1:0] {
        fromRegister  = 2'd0,
        fromMemory    = 2'd1,
        fromWriteback = 2'd2
    } ForwardSelect;

endpackage

// File: src/isaPkg.sv
////////////////////
// Instruction set types: opcodes, ALU codes and the instruction word layout
////////////////////
`include "cpu_defines.svh"

package isaPkg;

    // Major opcode, bits 31..27
    typedef enum logic [4:0] {
        opAlu  = 5'b00000,
        opJ    = 5'b00001,
        opBne  = 5'b00010,
        opAddi = 5'b00101,
        opBlt  = 5'b00110,
        opSw   = 5'b00111,
        opLw   = 5'b01000
    } Opcode;

    // R-type function, bits 6..2
    typedef enum logic [4:0] {
        aluAdd = 5'b00000,
        aluSub = 5'b00001,
        aluAnd = 5'b00010,
        aluOr  = 5'b00011,
        aluSll = 5'b00100,
        aluSra = 5'b00101
    } AluOp;

    // Immediate lives in bits 16..0, jump target in 26..0
    typedef struct packed {
        Opcode                          opcode;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rd;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rs;
        logic [`CPU_REG_ADDR_WIDTH-1:0] rt;
        logic [4:0]                     shamt;
        AluOp                           aluOp;
        logic [1:0]                     immLow;
    } Instruction;

    function automatic logic [`CPU_DATA_WIDTH-1:0] signExtendImmediate(Instruction instruction);
        return `CPU_DATA_WIDTH'($signed(instruction[16:0]));
    endfunction

    function automatic logic [`CPU_DATA_WIDTH-1:0] signExtendTarget(Instruction instruction);
        return `CPU_DATA_WIDTH'($signed(instruction[26:0]));
    endfunction

    // Instructions that produce a value for rd
    function automatic logic writesRegister(Instruction instruction);
        return instruction.opcode inside {opAlu, opAddi, opLw};
    endfunction

    // Branches compare rd, stores write out rd
    function automatic logic readsRdAsOperandB(Instruction instruction);
        return instruction.opcode inside {opBne, opBlt, opSw};
    endfunction

endpackage

// File: include/cpu_defines.svh
////////////////////
// Widths and depths shared by the core and its testbench
// Include this before any declaration that sizes a word or index
////////////////////
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Width of a data word and of the PC
`define CPU_DATA_WIDTH 32

// Register index width, five bits of each register field
`define CPU_REG_ADDR_WIDTH 5

// Architectural registers, r0 included
`define CPU_REG_COUNT 32

// Low address bits decoded by the instruction and data memories
`define CPU_DMEM_INDEX_WIDTH 8

`endif
